/* Makefile */
# Verilator build and run for the Z80 glue testbench

VERILATOR ?= verilator
TOP       ?= rc2014_glue_tb
FILELIST  ?= rc2014_glue.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= TESTBENCH PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* clock_enables.sv */
////////////////////////////////////////////////////////////
// Z80 clock-enable generator
// Divides clk_sys by 8 into falling and rising phase strobes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_enables (
	input  logic clk_sys,
	input  logic reset,
	output logic cpu_cen_n,
	output logic cpu_cen_p
);

	import rc2014_pkg::*;

	logic [CE_DIV_W-1:0] ce_cnt;	// Free-running phase counter

	// Both strobes come straight from flops so the core sees clean
	// single-cycle enables. Count 0 gives the falling half, the midpoint
	// of the count the rising half.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_cnt    <= '0;
			cpu_cen_n <= 1'b0;
			cpu_cen_p <= 1'b0;
		end else begin
			ce_cnt    <= ce_cnt + 1'b1;
			cpu_cen_n <= (ce_cnt == '0);
			cpu_cen_p <= (ce_cnt == {1'b1, {(CE_DIV_W-1){1'b0}}});	// Half period
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Half-cycles must never overlap
	a_cen_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(cpu_cen_n && cpu_cen_p)
	);

	// Rising phase lands exactly half a period after the falling one
	a_cen_phase: assert property (
		@(posedge clk_sys) disable iff (reset)
		cpu_cen_n |-> ##(2 ** (CE_DIV_W - 1)) cpu_cen_p
	);

endmodule

/* io_port_decode.sv */
////////////////////////////////////////////////////////////
// Z80 bus decode: I/O selects, memory strobes, SD bit-bang
// port and the processor read-data multiplexer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module io_port_decode (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  rc2014_pkg::cpu_addr_t                  cpu_addr,
	input  rc2014_pkg::data_t                      cpu_dout,
	input  logic                                   mreq_n,
	input  logic                                   iorq_n,
	input  logic                                   rd_n,
	input  logic                                   wr_n,
	input  logic                                   m1_n,
	input  rc2014_pkg::data_t                      boot_switches,
	input  logic                                   sd_miso,
	input  rc2014_pkg::data_t                      mem_q,
	output rc2014_pkg::data_t                      cpu_din,
	output logic                                   mem_rd,
	output logic                                   mem_wr_req,
	output logic                                   page_wr,
	output logic [$clog2(rc2014_pkg::NUM_BANKS)-1:0] page_index,
	output logic                                   page_ctrl_wr,
	output logic                                   sd_mosi,
	output logic                                   sd_clk,
	output logic                                   sd_cs
);

	import rc2014_pkg::*;

	data_t port_addr;
	logic  io_cycle;
	logic  io_wr;
	logic  sel_switches;
	logic  sel_sd;
	logic  sel_page;
	logic  sel_page_ctrl;
	logic  sd_wr;
	data_t sd_rd_data;

	////////////////////////////////////////////////////////////
	// Select decode

	assign port_addr = cpu_addr[DATA_W-1:0];	// Z80 I/O uses the low byte
	assign io_cycle  = !iorq_n && m1_n;		// M1 with IORQ is an interrupt ack
	assign io_wr     = io_cycle && !wr_n;

	assign sel_switches  = io_cycle && (port_addr == PORT_SWITCHES);
	assign sel_sd        = io_cycle && (port_addr == PORT_SD);
	assign sel_page      = io_cycle && (port_addr[DATA_W-1:2] == PORT_PAGE_BASE[DATA_W-1:2]);
	assign sel_page_ctrl = io_cycle && (port_addr == PORT_PAGE_CTRL);

	// Memory strobes, refresh cycles carry neither
	assign mem_rd     = !mreq_n && !rd_n;
	assign mem_wr_req = !mreq_n && !wr_n;

	// Strobes for the mapper, held while the OUT lasts
	assign page_wr      = io_wr && sel_page;
	assign page_index   = port_addr[$clog2(NUM_BANKS)-1:0];
	assign page_ctrl_wr = io_wr && sel_page_ctrl;

	////////////////////////////////////////////////////////////
	// SD bit-bang register

	assign sd_wr = io_wr && sel_sd;

	// Card deselected until software takes it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_cs   <= 1'b1;
			sd_clk  <= 1'b0;
			sd_mosi <= 1'b0;
		end else if (sd_wr) begin
			sd_cs   <= cpu_dout[SD_CS_BIT];
			sd_clk  <= cpu_dout[SD_CLK_BIT];
			sd_mosi <= cpu_dout[SD_MOSI_BIT];
		end
	end

	////////////////////////////////////////////////////////////
	// Read data

	always_comb begin
		sd_rd_data              = '0;
		sd_rd_data[SD_MISO_BIT] = sd_miso;	// Only MISO is readable
	end

	always_comb begin
		if (sel_switches)
			cpu_din = boot_switches;
		else if (sel_sd)
			cpu_din = sd_rd_data;
		else if (mem_rd)
			cpu_din = mem_q;
		else
			cpu_din = IDLE_READ;	// Page ports are write-only
	end

	// Port ranges must not overlap
	a_io_sel_onehot: assert property (
		@(posedge clk_sys) disable iff (reset)
		$onehot0({sel_switches, sel_sd, sel_page, sel_page_ctrl})
	);

endmodule

/* page_mapper.sv */
////////////////////////////////////////////////////////////
// 16 KB bank mapper from the 64 KB Z80 space into 1 MB,
// with registered memory address and RAM-only writes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module page_mapper (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  rc2014_pkg::cpu_addr_t                  cpu_addr,
	input  rc2014_pkg::data_t                      cpu_dout,
	input  logic                                   page_wr,
	input  logic [$clog2(rc2014_pkg::NUM_BANKS)-1:0] page_index,
	input  logic                                   page_ctrl_wr,
	input  logic                                   mem_wr_req,
	output rc2014_pkg::mem_addr_t                  mem_addr,
	output logic                                   mem_we
);

	import rc2014_pkg::*;

	page_t bank_page [NUM_BANKS];	// One page per 16 KB window
	logic  paging_en;
	page_t bank_sel;

	////////////////////////////////////////////////////////////
	// Bank registers

	// Only the low 6 bits of each OUT reach the decoder
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank_page <= PAGE_RESET;
			paging_en <= 1'b1;
		end else begin
			if (page_wr)
				bank_page[page_index] <= cpu_dout[PAGE_W-1:0];
			if (page_ctrl_wr)
				paging_en <= cpu_dout[0];
		end
	end

	////////////////////////////////////////////////////////////
	// Address translation

	// Top two CPU address bits pick the window
	assign bank_sel = paging_en ? bank_page[cpu_addr[CPU_ADDR_W-1:BANK_OFFSET_W]] : '0;

	// Registered for timing into the memory, one cycle behind cpu_addr
	always_ff @(posedge clk_sys) begin
		mem_addr <= {bank_sel, cpu_addr[BANK_OFFSET_W-1:0]};
	end

	// ROM half ignores writes
	assign mem_we = mem_wr_req && mem_addr[RAM_SEL_BIT];

	// The RAM bit has settled for a cycle before any write starts,
	// which holds as long as the address leads the write strobe
	a_we_ram_settled: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(mem_we) |-> mem_addr[RAM_SEL_BIT] && $stable(mem_addr[RAM_SEL_BIT])
	);

endmodule

/* rc2014_glue.f */
rc2014_pkg.sv
clock_enables.sv
io_port_decode.sv
page_mapper.sv
rc2014_glue.sv
rc2014_glue_tb.sv

/* rc2014_glue.sv */
////////////////////////////////////////////////////////////
// Z80 board glue top level: clock enables, I/O decode,
// SD port and bank mapper between CPU, memory and board
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rc2014_glue (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Processor bus
	input  rc2014_pkg::cpu_addr_t cpu_addr,
	input  rc2014_pkg::data_t     cpu_dout,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	output rc2014_pkg::data_t     cpu_din,
	output logic                  cpu_cen_n,
	output logic                  cpu_cen_p,

	// Memory
	output rc2014_pkg::mem_addr_t mem_addr,
	output logic                  mem_rd,
	output logic                  mem_we,
	output rc2014_pkg::data_t     mem_d,
	input  rc2014_pkg::data_t     mem_q,

	// Board
	input  rc2014_pkg::data_t     boot_switches,
	input  logic                  sd_miso,
	output logic                  sd_mosi,
	output logic                  sd_clk,
	output logic                  sd_cs
);

	import rc2014_pkg::*;

	logic                         page_wr;
	logic [$clog2(NUM_BANKS)-1:0] page_index;
	logic                         page_ctrl_wr;
	logic                         mem_wr_req;	// Before RAM gating

	assign mem_d = cpu_dout;	// Write data passes straight through

	clock_enables u_clock_enables (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_cen_n (cpu_cen_n),
		.cpu_cen_p (cpu_cen_p)
	);

	io_port_decode u_io_port_decode (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.mreq_n        (mreq_n),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.m1_n          (m1_n),
		.boot_switches (boot_switches),
		.sd_miso       (sd_miso),
		.mem_q         (mem_q),
		.cpu_din       (cpu_din),
		.mem_rd        (mem_rd),
		.mem_wr_req    (mem_wr_req),
		.page_wr       (page_wr),
		.page_index    (page_index),
		.page_ctrl_wr  (page_ctrl_wr),
		.sd_mosi       (sd_mosi),
		.sd_clk        (sd_clk),
		.sd_cs         (sd_cs)
	);

	page_mapper u_page_mapper (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.page_wr      (page_wr),
		.page_index   (page_index),
		.page_ctrl_wr (page_ctrl_wr),
		.mem_wr_req   (mem_wr_req),
		.mem_addr     (mem_addr),
		.mem_we       (mem_we)
	);

endmodule

/* rc2014_glue_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the Z80 glue top level
// Random bus cycles checked against a model of the board
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rc2014_glue_tb;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [7:0]  cpu_din;
	logic        cpu_cen_n;
	logic        cpu_cen_p;
	logic [19:0] mem_addr;
	logic        mem_rd;
	logic        mem_we;
	logic [7:0]  mem_d;
	logic [7:0]  mem_q;
	logic [7:0]  boot_switches;
	logic        sd_miso;
	logic        sd_mosi;
	logic        sd_clk;
	logic        sd_cs;

	integer seed = 32'h5869;

	// Reference state of the board
	logic [5:0] page_model [4];
	logic       paging_model;
	logic       sd_cs_model;
	logic       sd_clk_model;
	logic       sd_mosi_model;

	logic rst_at_edge = 1'b1;	// Reset as the DUT saw it on the last edge
	int   ce_count = 0;

	always #2 clk_sys = ~clk_sys;

	rc2014_glue u_rc2014_glue (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.mreq_n        (mreq_n),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.m1_n          (m1_n),
		.cpu_din       (cpu_din),
		.cpu_cen_n     (cpu_cen_n),
		.cpu_cen_p     (cpu_cen_p),
		.mem_addr      (mem_addr),
		.mem_rd        (mem_rd),
		.mem_we        (mem_we),
		.mem_d         (mem_d),
		.mem_q         (mem_q),
		.boot_switches (boot_switches),
		.sd_miso       (sd_miso),
		.sd_mosi       (sd_mosi),
		.sd_clk        (sd_clk),
		.sd_cs         (sd_cs)
	);

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			stop_run("Value mismatch");
		end
	endtask

	// Bank from the top two address bits, zero while paging is off
	function automatic logic [19:0] mapped(input logic [15:0] addr);
		logic [5:0] bank;
		bank = paging_model ? page_model[addr[15:14]] : 6'h00;
		return {bank, addr[13:0]};
	endfunction

	task automatic apply_write(input logic [7:0] port, input logic [7:0] data);
		if (port >= 8'h78 && port <= 8'h7B) begin
			page_model[port[1:0]] = data[5:0];
		end else if (port == 8'h7C) begin
			paging_model = data[0];
		end else if (port == 8'h69) begin
			sd_mosi_model = data[0];
			sd_cs_model   = data[3];
			sd_clk_model  = data[4];
		end
	endtask

	// Line a bus cycle up with the falling-phase enable
	task automatic wait_cen_n();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (cpu_cen_n !== 1'b1) begin
			if (n >= 16) begin
				stop_run("Timed out waiting for the cpu_cen_n pulse");
			end else begin
				n = n + 1;
				@(negedge clk_sys);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus cycles

	task automatic mem_cycle(input string name, input logic wr);
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  q;
		logic [19:0] exp_addr;
		addr     = 16'($random(seed));
		data     = 8'($random(seed));
		q        = 8'($random(seed));
		exp_addr = mapped(addr);
		wait_cen_n();
		@(posedge clk_sys);
		cpu_addr <= addr;
		cpu_dout <= data;
		mem_q    <= q;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check({name, " mem_addr"}, 32'(exp_addr), 32'(mem_addr));	// One cycle of latency
		@(posedge clk_sys);
		mreq_n <= 1'b0;
		rd_n   <= wr;
		wr_n   <= !wr;
		@(negedge clk_sys);
		check({name, " mem_addr held"}, 32'(exp_addr), 32'(mem_addr));
		check({name, " mem_we"}, 32'(wr & exp_addr[19]), 32'(mem_we));	// RAM only
		check({name, " mem_rd"}, 32'(!wr), 32'(mem_rd));
		if (wr)
			check({name, " mem_d"}, 32'(data), 32'(mem_d));
		else
			check({name, " cpu_din"}, 32'(q), 32'(cpu_din));
		@(posedge clk_sys);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		@(negedge clk_sys);
		check({name, " mem_we idle"}, 32'd0, 32'(mem_we));
		check({name, " mem_rd idle"}, 32'd0, 32'(mem_rd));
	endtask

	task automatic io_cycle(input string name, input logic [7:0] port, input logic wr,
			input logic [7:0] data);
		logic [7:0] sw;
		logic       miso;
		logic [7:0] exp_din;
		sw   = 8'($random(seed));
		miso = 1'($random(seed));
		if (port == 8'h00)
			exp_din = sw;
		else if (port == 8'h69)
			exp_din = {miso, 7'd0};	// MISO alone in bit 7
		else
			exp_din = 8'hFF;
		wait_cen_n();
		@(posedge clk_sys);
		cpu_addr      <= {8'($random(seed)), port};
		cpu_dout      <= data;
		boot_switches <= sw;
		sd_miso       <= miso;
		@(posedge clk_sys);
		@(posedge clk_sys);
		iorq_n <= 1'b0;
		rd_n   <= wr;
		wr_n   <= !wr;
		@(negedge clk_sys);
		if (!wr)
			check({name, " cpu_din"}, 32'(exp_din), 32'(cpu_din));
		check({name, " mem_rd"}, 32'd0, 32'(mem_rd));
		check({name, " mem_we"}, 32'd0, 32'(mem_we));
		@(posedge clk_sys);	// Registers take the write on this edge
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		if (wr)
			apply_write(port, data);
		@(negedge clk_sys);
		check({name, " sd_cs"}, 32'(sd_cs_model), 32'(sd_cs));
		check({name, " sd_clk"}, 32'(sd_clk_model), 32'(sd_clk));
		check({name, " sd_mosi"}, 32'(sd_mosi_model), 32'(sd_mosi));
	endtask

	////////////////////////////////////////////////////////////
	// Clock-enable monitor

	always @(posedge clk_sys)
		rst_at_edge <= reset;

	// Pattern restarts on the first edge out of reset
	always @(negedge clk_sys) begin
		if (rst_at_edge) begin
			ce_count = 0;
			check("cen_n in reset", 32'd0, 32'(cpu_cen_n));
			check("cen_p in reset", 32'd0, 32'(cpu_cen_p));
		end else begin
			check("cen_n phase", 32'((ce_count % 8) == 0), 32'(cpu_cen_n));
			check("cen_p phase", 32'((ce_count % 8) == 4), 32'(cpu_cen_p));
			ce_count = ce_count + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int i;
		reset         <= 1'b1;
		cpu_addr      <= '0;
		cpu_dout      <= '0;
		mreq_n        <= 1'b1;
		iorq_n        <= 1'b1;
		rd_n          <= 1'b1;
		wr_n          <= 1'b1;
		m1_n          <= 1'b1;
		mem_q         <= '0;
		boot_switches <= '0;
		sd_miso       <= 1'b0;
		page_model[0] = 6'h00;	// ROM low, top of RAM high
		page_model[1] = 6'h01;
		page_model[2] = 6'h3E;
		page_model[3] = 6'h3F;
		paging_model  = 1'b1;
		sd_cs_model   = 1'b1;
		sd_clk_model  = 1'b0;
		sd_mosi_model = 1'b0;

		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;

		// Reset state of SD port and banks
		wait_cen_n();
		check("reset sd_cs", 32'd1, 32'(sd_cs));
		check("reset sd_clk", 32'd0, 32'(sd_clk));
		check("reset sd_mosi", 32'd0, 32'(sd_mosi));
		for (i = 0; i < 8; i++)
			mem_cycle("reset map", 1'b0);

		// Bank writes mixed with accesses
		for (i = 0; i < 40; i++) begin
			if (1'($random(seed)))
				io_cycle("bank write", {6'b011110, 2'($random(seed))}, 1'b1,
					8'($random(seed)));
			else
				mem_cycle("banked access", 1'($random(seed)));
		end

		// Paging off and back on
		io_cycle("paging off", 8'h7C, 1'b1, 8'($random(seed)) & 8'hFE);
		for (i = 0; i < 10; i++)
			mem_cycle("flat map", 1'($random(seed)));
		io_cycle("paging on", 8'h7C, 1'b1, 8'($random(seed)) | 8'h01);
		for (i = 0; i < 10; i++)
			mem_cycle("banked again", 1'($random(seed)));

		// Writes split between ROM and RAM
		for (i = 0; i < 30; i++)
			mem_cycle("memory write", 1'b1);

		// I/O ports
		for (i = 0; i < 6; i++)
			io_cycle("switch read", 8'h00, 1'b0, 8'h00);
		for (i = 0; i < 6; i++)
			io_cycle("sd read", 8'h69, 1'b0, 8'h00);
		for (i = 0; i < 10; i++)
			io_cycle("sd write", 8'h69, 1'b1, 8'($random(seed)));
		for (i = 0; i < 6; i++) begin
			io_cycle("unmapped read", {1'b1, 7'($random(seed))}, 1'b0, 8'h00);
			io_cycle("page port read", {6'b011110, 2'($random(seed))}, 1'b0, 8'h00);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* rc2014_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, I/O port addresses and bus types for the
// Z80 board glue logic
////////////////////////////////////////////////////////////

package rc2014_pkg;

	// Bus widths
	localparam int CPU_ADDR_W    = 16;
	localparam int DATA_W        = 8;
	localparam int MEM_ADDR_W    = 20;	// 1 MB behind the mapper
	localparam int BANK_OFFSET_W = 14;	// 16 KB window
	localparam int PAGE_W        = 6;
	localparam int NUM_BANKS     = 4;
	localparam int RAM_SEL_BIT   = 19;	// Upper 512 KB is RAM
	localparam int CE_DIV_W      = 3;	// clk_sys / 8

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [PAGE_W-1:0]     page_t;

	////////////////////////////////////////////////////////////
	// I/O map, matched on the low address byte
	localparam data_t PORT_SWITCHES  = 8'h00;
	localparam data_t PORT_SD        = 8'h69;
	localparam data_t PORT_PAGE_BASE = 8'h78;	// Banks at 0x78..0x7B
	localparam data_t PORT_PAGE_CTRL = 8'h7C;

	// SD port byte layout
	localparam int SD_MOSI_BIT = 0;
	localparam int SD_CS_BIT   = 3;
	localparam int SD_CLK_BIT  = 4;
	localparam int SD_MISO_BIT = 7;

	// Power-up banks, ROM low and top of RAM high
	localparam page_t PAGE_RESET [NUM_BANKS] = '{6'h00, 6'h01, 6'h3E, 6'h3F};

	// Floating bus value
	localparam data_t IDLE_READ = 8'hFF;

endpackage
